//--- common/arbPkg.sv
package arbPkg;

  // Number of request lines handled by the arbiter
  localparam int CLineCnt = 8;

  // Width of a line index
  localparam int CIdxLen = $clog2(CLineCnt);

  // One bit per request line
  typedef logic [CLineCnt-1:0] lineVecT;

  // Line number
  typedef logic [CIdxLen-1:0] lineIdxT;

  // Debounced request levels leaving the filter stage
  typedef struct packed
  {
    lineVecT lines;
  } filtReqT;

  // Registered one-hot grant leaving the arbiter stage
  typedef struct packed
  {
    lineVecT oneHot;
    logic    any;
  } grantT;

  // Final result, the granted line as an index
  typedef struct packed
  {
    logic    valid;
    lineIdxT idx;
  } grantIdxT;

endpackage

//--- rtl/reqFilter.sv
module reqFilter #(
  parameter int FilterLen = 4
)
(
  input  logic            AClkB,
  input  logic            AResetBN,
  input  arbPkg::lineVecT ReqLines,
  output arbPkg::filtReqT FiltReq
);

  localparam int CLineCnt = arbPkg::CLineCnt;

  // Sample history per line, bit 0 holds the newest sample
  logic [CLineCnt-1:0][FilterLen-1:0] FHistory;
  logic [CLineCnt-1:0][FilterLen-1:0] BHistory;

  // Filtered level per line
  arbPkg::lineVecT FLevel;
  arbPkg::lineVecT BLevel;

  // Per-line history summaries
  arbPkg::lineVecT BHistAll;
  arbPkg::lineVecT BHistNone;

  // Shift the raw sample into each line's history
  always_comb
  begin
    for (int l = 0; l < CLineCnt; l++)
    begin
      BHistory[l][0] = ReqLines[l];
      for (int k = 1; k < FilterLen; k++)
      begin
        BHistory[l][k] = FHistory[l][k-1];
      end
    end
  end

  // All ones sets the level, all zeros clears it
  always_comb
  begin
    for (int l = 0; l < CLineCnt; l++)
    begin
      BHistAll[l]  = &FHistory[l];
      BHistNone[l] = ~(|FHistory[l]);
    end
  end

  // Mixed history keeps the previous level, so short pulses never get through
  always_comb
  begin
    for (int l = 0; l < CLineCnt; l++)
    begin
      if (BHistAll[l])
      begin
        BLevel[l] = 1'b1;
      end
      else if (BHistNone[l])
      begin
        BLevel[l] = 1'b0;
      end
      else
      begin
        BLevel[l] = FLevel[l];
      end
    end
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      FHistory <= '0;
    end
    else
    begin
      FHistory <= BHistory;
    end
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      FLevel <= '0;
    end
    else
    begin
      FLevel <= BLevel;
    end
  end

  assign FiltReq.lines = FLevel;

endmodule

//--- arbiter/rrArbiter.sv
module rrArbiter
(
  input  logic            AClkB,
  input  logic            AResetBN,
  input  arbPkg::filtReqT FiltReq,
  output arbPkg::grantT   Grant
);

  localparam int CLineCnt = arbPkg::CLineCnt;

  // One-hot priority pointer
  arbPkg::lineVecT FPointer;
  arbPkg::lineVecT BPointer;

  // Registered grant
  arbPkg::grantT FGrant;
  arbPkg::grantT BGrant;

  // Requests rotated so that the pointer position lands on bit 0
  arbPkg::lineVecT BRotReq;
  arbPkg::lineVecT BRotPrefix;
  arbPkg::lineVecT BRotMasked;

  // Winner in the original line order
  arbPkg::lineVecT BSelected;

  arbPkg::lineVecT BPointerRol;
  logic            BAnyReq;
  logic            BHold;

  assign BAnyReq = |FiltReq.lines;

  // Previous owner still asks, so nobody else gets in
  assign BHold = |(FiltReq.lines & FGrant.oneHot);

  // Rotate right by the pointer position
  always_comb
  begin
    BRotReq = '0;
    for (int k = 0; k < CLineCnt; k++)
    begin
      for (int j = 0; j < CLineCnt; j++)
      begin
        BRotReq[j] = BRotReq[j] | (FPointer[k] & FiltReq.lines[(k + j) % CLineCnt]);
      end
    end
  end

  // Keep the lowest set bit only
  always_comb
  begin
    BRotPrefix[0] = BRotReq[0];
    BRotMasked[0] = BRotReq[0];
    for (int i = 1; i < CLineCnt; i++)
    begin
      BRotPrefix[i] = BRotReq[i] | BRotPrefix[i-1];
      BRotMasked[i] = BRotReq[i] & ~BRotPrefix[i-1];
    end
  end

  // Rotate the winner back by the same amount
  always_comb
  begin
    BSelected = '0;
    for (int k = 0; k < CLineCnt; k++)
    begin
      for (int j = 0; j < CLineCnt; j++)
      begin
        BSelected[(k + j) % CLineCnt] = BSelected[(k + j) % CLineCnt]
                                      | (FPointer[k] & BRotMasked[j]);
      end
    end
  end

  // Pointer moves one line up, the top line wraps to line 0
  always_comb
  begin
    BPointerRol[0] = FPointer[CLineCnt-1];
    for (int i = 1; i < CLineCnt; i++)
    begin
      BPointerRol[i] = FPointer[i-1];
    end
  end

  always_comb
  begin
    if (BHold)
    begin
      BGrant.oneHot = FGrant.oneHot;
      BPointer      = FPointer;
    end
    else if (BAnyReq)
    begin
      BGrant.oneHot = BSelected;
      BPointer      = BPointerRol;
    end
    else
    begin
      // Idle, the pointer waits where it is
      BGrant.oneHot = '0;
      BPointer      = FPointer;
    end
    BGrant.any = |BGrant.oneHot;
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      FPointer <= arbPkg::lineVecT'(1);
    end
    else
    begin
      FPointer <= BPointer;
    end
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      FGrant <= '0;
    end
    else
    begin
      FGrant <= BGrant;
    end
  end

  assign Grant = FGrant;

endmodule

//--- arbiter/grantEncoder.sv
module grantEncoder
(
  input  logic             AClkB,
  input  logic             AResetBN,
  input  arbPkg::grantT    Grant,
  output arbPkg::grantIdxT GrantOut
);

  localparam int CLineCnt = arbPkg::CLineCnt;

  arbPkg::lineIdxT  BIdx;
  arbPkg::grantIdxT BGrantOut;
  arbPkg::grantIdxT FGrantOut;

  // OR of the line numbers whose one-hot bit is set
  always_comb
  begin
    BIdx = '0;
    for (int i = 0; i < CLineCnt; i++)
    begin
      if (Grant.oneHot[i])
      begin
        BIdx = BIdx | arbPkg::lineIdxT'(i);
      end
    end
  end

  // No grant gives index 0 with valid low
  always_comb
  begin
    BGrantOut.valid = Grant.any;
    BGrantOut.idx   = BIdx;
  end

  always_ff @(posedge AClkB or negedge AResetBN)
  begin
    if (!AResetBN)
    begin
      FGrantOut <= '0;
    end
    else
    begin
      FGrantOut <= BGrantOut;
    end
  end

  assign GrantOut = FGrantOut;

endmodule

//--- rtl/debouncedArbiter.sv
module debouncedArbiter #(
  parameter int FilterLen = 4
)
(
  input  logic             AClkB,
  input  logic             AResetBN,
  input  arbPkg::lineVecT  ReqLines,
  output arbPkg::grantIdxT GrantOut
);

  // Stage outputs
  arbPkg::filtReqT FiltReq;
  arbPkg::grantT   Grant;

  // Stage 1, debounce, latency FilterLen
  reqFilter #(
    .FilterLen (FilterLen)
  ) u_reqFilter
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .ReqLines (ReqLines),
    .FiltReq  (FiltReq)
  );

  // Stage 2, rotating priority pick, latency 1
  rrArbiter u_rrArbiter
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .FiltReq  (FiltReq),
    .Grant    (Grant)
  );

  // Stage 3, one-hot to index, latency 1
  grantEncoder u_grantEncoder
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .Grant    (Grant),
    .GrantOut (GrantOut)
  );

endmodule

//--- verification/arbChecker.sv
module arbChecker #(
  parameter int FilterLen = 4
)
(
  input  logic             AClkB,
  input  logic             AResetBN,
  input  arbPkg::lineVecT  ReqLines,
  input  arbPkg::grantIdxT GrantOut,
  output logic             Failed
);

  localparam int CLineCnt = arbPkg::CLineCnt;

  logic [FilterLen-1:0] modelHist [CLineCnt];
  arbPkg::lineVecT      modelLevel;
  arbPkg::lineVecT      modelGrant;
  arbPkg::grantIdxT     modelOut;
  int                   modelPtr;
  logic                 failSeen = 1'b0;

  assign Failed = failSeen;

  // First requested line at or above start, wrapping; -1 when nothing is requested
  function automatic int firstFrom(arbPkg::lineVecT req, int start);
    int pos;
    firstFrom = -1;
    for (int i = 0; i < CLineCnt; i++)
    begin
      pos = (start + i) % CLineCnt;
      if (req[pos] && firstFrom < 0)
      begin
        firstFrom = pos;
      end
    end
  endfunction

  function automatic arbPkg::lineIdxT lineOf(arbPkg::lineVecT oneHot);
    lineOf = '0;
    for (int i = 0; i < CLineCnt; i++)
    begin
      if (oneHot[i])
      begin
        lineOf = arbPkg::lineIdxT'(i);
      end
    end
  endfunction

  always @(posedge AClkB or negedge AResetBN)
  begin : modelStep
    int pick;
    if (!AResetBN)
    begin
      for (int l = 0; l < CLineCnt; l++)
      begin
        modelHist[l] <= '0;
      end
      modelLevel <= '0;
      modelGrant <= '0;
      modelPtr   <= 0;
      modelOut   <= '0;
    end
    else
    begin
      // Levels follow the history as it stood before this sample
      for (int l = 0; l < CLineCnt; l++)
      begin
        modelHist[l] <= (modelHist[l] << 1) | FilterLen'(ReqLines[l]);
        if (&modelHist[l])
        begin
          modelLevel[l] <= 1'b1;
        end
        else if (~|modelHist[l])
        begin
          modelLevel[l] <= 1'b0;
        end
      end
      if ((modelLevel & modelGrant) == '0)
      begin
        pick = firstFrom(modelLevel, modelPtr);
        if (pick < 0)
        begin
          modelGrant <= '0;
        end
        else
        begin
          modelGrant <= arbPkg::lineVecT'(1) << pick;
          modelPtr   <= (modelPtr + 1) % CLineCnt;
        end
      end
      modelOut.valid <= |modelGrant;
      modelOut.idx   <= lineOf(modelGrant);
    end
  end

  validMatch : assert property (@(posedge AClkB) disable iff (!AResetBN)
    GrantOut.valid == modelOut.valid)
  else
  begin
    $display("Mismatch at %0t: valid is %0b, model expects %0b", $time,
             $sampled(GrantOut.valid), $sampled(modelOut.valid));
    failSeen = 1'b1;
  end

  idxMatch : assert property (@(posedge AClkB) disable iff (!AResetBN)
    GrantOut.idx == modelOut.idx)
  else
  begin
    $display("Mismatch at %0t: index is %0d, model expects %0d", $time,
             $sampled(GrantOut.idx), $sampled(modelOut.idx));
    failSeen = 1'b1;
  end

endmodule

//--- verification/tbDebouncedArbiter.sv
module tbDebouncedArbiter;

  localparam int CFilterLen = 4;
  localparam int CLineCnt   = arbPkg::CLineCnt;
  // About twice the length of all stimulus phases
  localparam int CMaxCycles = 2000;

  logic             AClkB;
  logic             AResetBN;
  arbPkg::lineVecT  ReqLines;
  arbPkg::grantIdxT GrantOut;
  logic             checkFailed;
  int               cycleCnt = 0;
  integer           seed;

  debouncedArbiter #(
    .FilterLen (CFilterLen)
  ) u_debouncedArbiter
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .ReqLines (ReqLines),
    .GrantOut (GrantOut)
  );

  arbChecker #(
    .FilterLen (CFilterLen)
  ) u_arbChecker
  (
    .AClkB    (AClkB),
    .AResetBN (AResetBN),
    .ReqLines (ReqLines),
    .GrantOut (GrantOut),
    .Failed   (checkFailed)
  );

  initial
  begin
    AClkB = 1'b0;
    forever #2 AClkB = ~AClkB;
  end

  always @(posedge AClkB)
  begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= CMaxCycles)
    begin
      $display("Timeout: the stimulus did not finish within %0d cycles", CMaxCycles);
      $display("sim failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  initial
  begin
    @(posedge checkFailed);
    $display("sim failed");
    $fatal(1, "Model comparison failed");
  end

  task automatic nextCycle();
    @(posedge AClkB);
    #1;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) nextCycle();
  endtask

  task automatic waitGrantFor(input int line);
    while (!(GrantOut.valid && int'(GrantOut.idx) == line))
    begin
      nextCycle();
    end
  endtask

  // Requesters drop their line a random time after they see their own index
  task automatic serveRound(input arbPkg::lineVecT startMask);
    arbPkg::lineVecT served;
    int              countdown [CLineCnt];
    int              owner;
    served = '0;
    for (int l = 0; l < CLineCnt; l++)
    begin
      countdown[l] = 0;
    end
    ReqLines = startMask;
    while (ReqLines != '0)
    begin
      nextCycle();
      owner = int'(GrantOut.idx);
      if (GrantOut.valid && ReqLines[owner] && !served[owner])
      begin
        served[owner]    = 1'b1;
        countdown[owner] = 1 + int'($unsigned($random(seed)) % 6);
      end
      for (int l = 0; l < CLineCnt; l++)
      begin
        if (served[l] && ReqLines[l])
        begin
          countdown[l] = countdown[l] - 1;
          if (countdown[l] == 0)
          begin
            ReqLines[l] = 1'b0;
          end
        end
      end
    end
    idleCycles(CFilterLen + 4);
  endtask

  // Stable requests change now and then, single-cycle glitches ride on top
  task automatic randomPhase(input int cycles);
    arbPkg::lineVecT stable;
    arbPkg::lineVecT glitch;
    int              r;
    stable = '0;
    for (int c = 0; c < cycles; c++)
    begin
      r      = $random(seed);
      glitch = '0;
      if (r[2:0] == 3'd0)
      begin
        stable[r[10:8]] = ~stable[r[10:8]];
      end
      if (r[5:4] == 2'd0)
      begin
        glitch[r[14:12]] = 1'b1;
      end
      ReqLines = stable ^ glitch;
      nextCycle();
    end
    ReqLines = '0;
    idleCycles(CFilterLen + 4);
  endtask

  initial
  begin
    arbPkg::lineVecT mask;
    seed     = 32'h5baa;
    AResetBN = 1'b0;
    ReqLines = '0;
    repeat (10) @(posedge AClkB);
    #1;
    AResetBN = 1'b1;
    idleCycles(20);

    for (int l = 0; l < CLineCnt; l++)
    begin
      for (int w = 1; w < CFilterLen; w++)
      begin
        ReqLines = arbPkg::lineVecT'(1) << l;
        idleCycles(w);
        ReqLines = '0;
        idleCycles(CFilterLen + 2);
      end
    end

    for (int l = 0; l < CLineCnt; l++)
    begin
      ReqLines = arbPkg::lineVecT'(1) << l;
      waitGrantFor(l);
      idleCycles(4);
      ReqLines = '0;
      idleCycles(CFilterLen + 4);
    end

    // Owner on line 2 keeps the grant while other lines join
    ReqLines = 8'b0000_0100;
    waitGrantFor(2);
    ReqLines = ReqLines | 8'b0110_0001;
    idleCycles(15);
    ReqLines = '0;
    idleCycles(CFilterLen + 4);

    serveRound(8'hff);
    for (int i = 0; i < 3; i++)
    begin
      mask = arbPkg::lineVecT'($random(seed));
      if (mask == '0)
      begin
        mask = 8'h81;
      end
      serveRound(mask);
    end

    randomPhase(400);

    nextCycle();
    if (checkFailed)
    begin
      $display("sim failed");
      $fatal(1, "Model comparison failed");
    end
    else
    begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- debouncedArbiter.f
common/arbPkg.sv
rtl/reqFilter.sv
arbiter/rrArbiter.sv
arbiter/grantEncoder.sv
rtl/debouncedArbiter.sv
verification/arbChecker.sv
verification/tbDebouncedArbiter.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the debounced arbiter testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

top=tbDebouncedArbiter
buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert \
  --top-module "$top" -Mdir "$buildDir" \
  -f debouncedArbiter.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$buildDir/V$top" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if [ ! -f "$logFile" ]; then
  echo "No simulation log was written"
  exit 1
fi

if grep -q "sim failed" "$logFile"; then
  echo "Testbench reported a failure"
  exit 1
fi

if [ $simStatus -ne 0 ]; then
  echo "Simulator exited with status $simStatus"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
